// ==== compile.f ====
+incdir+rtl
rtl/conv_pkg.sv
rtl/conv_ctrl.sv
rtl/weight_codebook.sv
rtl/conv_lane.sv
rtl/conv_3x3_top.sv
dv/sram_model.sv
dv/tb_conv_3x3.sv

// ==== dv/sram_model.sv ====
module sram_model #(
	parameter int DEPTH = 1024
) (
	input logic clk,
	input conv_pkg::sram_req_t req,
	output conv_pkg::word_t rdata
);
	timeunit 1ns;
	timeprecision 100ps;
	import conv_pkg::*;

	// preloaded by the testbench through hierarchy
	word_t mem [DEPTH];

	initial rdata = '0;

	// read data valid one cycle after the request
	always @(posedge clk) begin
		if (req.cs && req.we)
			mem[req.addr] <= req.wdata;
		else if (req.cs)
			rdata <= mem[req.addr];
	end

endmodule

// ==== dv/tb_conv_3x3.sv ====
module tb_conv_3x3;
	timeunit 1ns;
	timeprecision 100ps;
	import conv_pkg::*;

	function automatic int run_cycles(input int n, input int c, input int k);
		return 4 + k * (2 + n * n * (14 * c + 1)) + 1;
	endfunction

	// all runs of all tests, doubled, plus slack for reset and idle checks
	localparam int CYCLE_LIMIT = 2 * (run_cycles(4, 1, 1) + run_cycles(4, 3, 2)
		+ run_cycles(4, 1, 2) + 2 * run_cycles(4, 2, 1) + run_cycles(5, 2, 2)) + 100;

	logic clk;
	logic rstn;
	logic start;
	logic finish;
	word_t codebook;
	sram_req_t param_req;
	sram_req_t bias_req;
	sram_req_t weight_req;
	sram_req_t img0_req;
	sram_req_t img1_req;
	sram_req_t out0_req;
	sram_req_t out1_req;
	word_t param_rdata;
	word_t bias_rdata;
	word_t weight_rdata;
	word_t img0_rdata;
	word_t img1_rdata;

	int cycles = 0;
	int cur_n;
	int cur_c;
	int cur_k;
	word_t cur_cb;

	sram_model u_param (.clk(clk), .req(param_req), .rdata(param_rdata));
	sram_model u_bias (.clk(clk), .req(bias_req), .rdata(bias_rdata));
	sram_model u_weight (.clk(clk), .req(weight_req), .rdata(weight_rdata));
	sram_model u_img0 (.clk(clk), .req(img0_req), .rdata(img0_rdata));
	sram_model u_img1 (.clk(clk), .req(img1_req), .rdata(img1_rdata));
	sram_model u_out0 (.clk(clk), .req(out0_req), .rdata());
	sram_model u_out1 (.clk(clk), .req(out1_req), .rdata());

	conv_3x3_top u_dut (
		.clk(clk),
		.rstn(rstn),
		.start(start),
		.codebook(codebook),
		.finish(finish),
		.param_req(param_req),
		.param_rdata(param_rdata),
		.bias_req(bias_req),
		.bias_rdata(bias_rdata),
		.weight_req(weight_req),
		.weight_rdata(weight_rdata),
		.img0_req(img0_req),
		.img0_rdata(img0_rdata),
		.img1_req(img1_req),
		.img1_rdata(img1_rdata),
		.out0_req(out0_req),
		.out1_req(out1_req)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run went past %0d cycles", CYCLE_LIMIT);
			$display("*** FAILED ***");
			$fatal(1, "simulation timed out");
		end
	end

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("error %s: expected %h, actual %h", name, exp, act);
			$display("*** FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	// low byte is a pixel in -span/2 .. span/2-1, upper bytes are noise
	task automatic fill_images(input int words, input int span);
		for (int i = 0; i < words; i++) begin
			u_img0.mem[i] = ($urandom & 32'hffff_ff00)
				| (($urandom % span - span / 2) & 8'hff);
			u_img1.mem[i] = ($urandom & 32'hffff_ff00)
				| (($urandom % span - span / 2) & 8'hff);
		end
	endtask

	task automatic run_conv(input string name, input int n, input int c, input int k,
		input word_t cb);
		cur_n = n;
		cur_c = c;
		cur_k = k;
		cur_cb = cb;
		u_param.mem[0] = n;
		u_param.mem[1] = c;
		u_param.mem[2] = k;
		for (int i = 0; i < k * n * n; i++) begin
			u_out0.mem[i] = 32'hbad0_0000 | i;
			u_out1.mem[i] = 32'hbad1_0000 | i;
		end
		codebook = cb;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		// the codebook is only sampled with start
		codebook = ~cb;
		check_value({name, " finish low while running"}, 0, finish);
		while (!finish)
			@(negedge clk);
	endtask

	// padded 3x3 sum over all channels, 16-bit wrap, then quantize
	function automatic logic [7:0] ref_pixel(input int lane, input int k, input int y,
		input int x);
		logic signed [15:0] acc;
		logic [31:0] wword;
		logic [31:0] pword;
		int code;
		int w;
		int p;
		int yy;
		int xx;
		acc = u_bias.mem[k][15:0];
		for (int ch = 0; ch < cur_c; ch++) begin
			wword = u_weight.mem[k * cur_c + ch];
			for (int t = 0; t < 9; t++) begin
				yy = y + t / 3 - 1;
				xx = x + t % 3 - 1;
				code = wword[2 * t +: 2];
				w = $signed(cur_cb[8 * code +: 8]);
				if (yy < 0 || xx < 0 || yy >= cur_n || xx >= cur_n) begin
					p = 0;
				end else begin
					pword = lane ? u_img1.mem[ch * cur_n * cur_n + yy * cur_n + xx]
						: u_img0.mem[ch * cur_n * cur_n + yy * cur_n + xx];
					p = $signed(pword[7:0]);
				end
				acc = acc + 16'(p * w);
			end
		end
		if (acc[15])
			return 8'h00;
		if (acc[14:12] != 3'b000)
			return 8'h7f;
		return acc[12:5];
	endfunction

	task automatic expect_outputs(input string name);
		int addr;
		for (int k = 0; k < cur_k; k++) begin
			for (int y = 0; y < cur_n; y++) begin
				for (int x = 0; x < cur_n; x++) begin
					addr = k * cur_n * cur_n + y * cur_n + x;
					check_value({name, " lane0"}, {24'h0, ref_pixel(0, k, y, x)},
						u_out0.mem[addr]);
					check_value({name, " lane1"}, {24'h0, ref_pixel(1, k, y, x)},
						u_out1.mem[addr]);
				end
			end
		end
	endtask

	task automatic test_reset_idle();
		for (int i = 0; i < 4; i++) begin
			check_value("reset_idle finish", 0, finish);
			check_value("reset_idle cs", 0, {param_req.cs, bias_req.cs, weight_req.cs,
				img0_req.cs, img1_req.cs, out0_req.cs, out1_req.cs});
			check_value("reset_idle we", 0, {out0_req.we, out1_req.we});
			@(negedge clk);
		end
	endtask

	task automatic test_border();
		fill_images(16, 256);
		u_bias.mem[0] = 32'h0000_0040;
		// only the top-left tap selects a nonzero byte
		u_weight.mem[0] = 32'h0000_0001;
		run_conv("border", 4, 1, 1, 32'h0000_2000);
		expect_outputs("border");
	endtask

	task automatic test_multi_channel();
		fill_images(48, 64);
		for (int i = 0; i < 2; i++)
			u_bias.mem[i] = ($urandom & 32'hffff_0000) | ($urandom % 1024);
		for (int i = 0; i < 6; i++)
			u_weight.mem[i] = $urandom;
		run_conv("multi_channel", 4, 3, 2, 32'hfd03_ff02);
		expect_outputs("multi_channel");
	endtask

	task automatic test_saturation();
		for (int i = 0; i < 16; i++) begin
			u_img0.mem[i] = 32'd50;
			u_img1.mem[i] = 32'd50;
		end
		u_bias.mem[0] = 32'h0000_0f00;
		u_bias.mem[1] = 32'h0000_0100;
		// all codes 1 (+10), then all codes 2 (-10)
		u_weight.mem[0] = 32'h0001_5555;
		u_weight.mem[1] = 32'h0002_aaaa;
		run_conv("saturation", 4, 1, 2, 32'h00f6_0a00);
		expect_outputs("saturation");
		check_value("saturation high", 32'h7f, u_out0.mem[0]);
		check_value("saturation low", 32'h00, u_out1.mem[16]);
	endtask

	task automatic test_codebook();
		fill_images(32, 256);
		u_bias.mem[0] = 32'h0000_0000;
		u_weight.mem[0] = $urandom;
		u_weight.mem[1] = $urandom;
		run_conv("codebook_a", 4, 2, 1, 32'h0403_0201);
		expect_outputs("codebook_a");
		run_conv("codebook_b", 4, 2, 1, 32'hfe10_80f0);
		expect_outputs("codebook_b");
	endtask

	task automatic test_restart();
		fill_images(50, 128);
		for (int i = 0; i < 2; i++)
			u_bias.mem[i] = $urandom % 2048;
		for (int i = 0; i < 4; i++)
			u_weight.mem[i] = $urandom;
		run_conv("restart", 5, 2, 2, $urandom);
		expect_outputs("restart");
	endtask

	initial begin
		void'($urandom(32'h4b96));
		clk = 1'b0;
		rstn = 1'b0;
		start = 1'b0;
		codebook = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		test_reset_idle();
		test_border();
		test_multi_channel();
		test_saturation();
		test_codebook();
		test_restart();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== rtl/conv_3x3_top.sv ====
module conv_3x3_top (
	input logic clk,
	input logic rstn,
	input logic start,
	input conv_pkg::word_t codebook,
	output logic finish,
	output conv_pkg::sram_req_t param_req,
	input conv_pkg::word_t param_rdata,
	output conv_pkg::sram_req_t bias_req,
	input conv_pkg::word_t bias_rdata,
	output conv_pkg::sram_req_t weight_req,
	input conv_pkg::word_t weight_rdata,
	output conv_pkg::sram_req_t img0_req,
	input conv_pkg::word_t img0_rdata,
	output conv_pkg::sram_req_t img1_req,
	input conv_pkg::word_t img1_rdata,
	output conv_pkg::sram_req_t out0_req,
	output conv_pkg::sram_req_t out1_req
);
	import conv_pkg::*;

	sram_req_t pix_req;
	sram_req_t out_req;
	lane_ctl_t lane_ctl;
	taps_t taps;
	logic wgt_load;
	pix_t result0;
	pix_t result1;

	conv_ctrl u_ctrl (
		.clk(clk),
		.rstn(rstn),
		.start(start),
		.finish(finish),
		.param_req(param_req),
		.bias_req(bias_req),
		.weight_req(weight_req),
		.pix_req(pix_req),
		.out_req(out_req),
		.param_rdata(param_rdata),
		.bias_rdata(bias_rdata),
		.wgt_load(wgt_load),
		.lane_ctl(lane_ctl)
	);

	weight_codebook u_codebook (
		.clk(clk),
		.rstn(rstn),
		.start(start),
		.codebook(codebook),
		.wgt_load(wgt_load),
		.weight_rdata(weight_rdata),
		.taps(taps)
	);

	conv_lane u_lane0 (
		.clk(clk),
		.rstn(rstn),
		.lane_ctl(lane_ctl),
		.taps(taps),
		.pix_rdata(img0_rdata),
		.result(result0)
	);

	conv_lane u_lane1 (
		.clk(clk),
		.rstn(rstn),
		.lane_ctl(lane_ctl),
		.taps(taps),
		.pix_rdata(img1_rdata),
		.result(result1)
	);

	// both images share one address stream
	assign img0_req = pix_req;
	assign img1_req = pix_req;

	assign out0_req = '{cs: out_req.cs, we: out_req.we, addr: out_req.addr,
		wdata: word_t'($unsigned(result0))};
	assign out1_req = '{cs: out_req.cs, we: out_req.we, addr: out_req.addr,
		wdata: word_t'($unsigned(result1))};

endmodule

// ==== rtl/conv_cfg.svh ====
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// memory port widths
`define CONV_ADDR_W 16
`define CONV_WORD_W 32

// largest image side, limit for channels and kernels
`define CONV_MAX_N 32
`define CONV_MAX_CH 1024

// 3x3 window
`define CONV_TAPS 9

// partial sum width, wraps on overflow
`define CONV_ACC_W 16

// cycles from read request to read data
`define CONV_RD_LAT 1

`endif

// ==== rtl/conv_ctrl.sv ====
`include "conv_cfg.svh"

module conv_ctrl (
	input logic clk,
	input logic rstn,
	input logic start,
	output logic finish,
	output conv_pkg::sram_req_t param_req,
	output conv_pkg::sram_req_t bias_req,
	output conv_pkg::sram_req_t weight_req,
	output conv_pkg::sram_req_t pix_req,
	output conv_pkg::sram_req_t out_req,
	input conv_pkg::word_t param_rdata,
	input conv_pkg::word_t bias_rdata,
	output logic wgt_load,
	output conv_pkg::lane_ctl_t lane_ctl
);
	import conv_pkg::*;

	localparam int XW = $clog2(`CONV_MAX_N);
	localparam int NW = $clog2(`CONV_MAX_N + 1);
	localparam int KW = $clog2(`CONV_MAX_CH);
	localparam int CW = $clog2(`CONV_MAX_CH + 1);
	localparam int PARAM_LAST = 2 + `CONV_RD_LAT;
	localparam int FETCH_LAST = `CONV_TAPS - 1 + `CONV_RD_LAT;

	typedef enum logic [3:0] {
		st_idle,
		st_load_param,
		st_load_bias,
		st_load_weight,
		st_fetch,
		st_multiply,
		st_accumulate,
		st_write,
		st_finish
	} state_t;

	state_t state;
	state_t next_state;
	logic [3:0] cnt;
	logic accept;

	logic [NW-1:0] n_side;
	logic [CW-1:0] n_ch;
	logic [CW-1:0] n_ker;
	logic [2*NW-1:0] n_sq;
	word_t bias_q;

	logic [XW-1:0] x_cnt;
	logic [XW-1:0] y_cnt;
	logic [KW-1:0] ch_cnt;
	logic [KW-1:0] k_cnt;
	logic x_last;
	logic y_last;
	logic ch_last;
	logic k_last;

	logic [1:0] tap_row;
	logic [1:0] tap_col;
	logic [XW+1:0] yy;
	logic [XW+1:0] xx;
	logic pad;
	logic pad_q;
	logic [31:0] pix_lin;
	logic [31:0] out_lin;
	logic [31:0] wgt_lin;

	assign accept = start && (state == st_idle || state == st_finish);

	assign x_last = ({1'b0, x_cnt} == n_side - 1'b1);
	assign y_last = ({1'b0, y_cnt} == n_side - 1'b1);
	assign ch_last = ({1'b0, ch_cnt} == n_ch - 1'b1);
	assign k_last = ({1'b0, k_cnt} == n_ker - 1'b1);
	assign n_sq = n_side * n_side;

	always_comb begin
		next_state = state;
		case (state)
			st_idle: if (start) next_state = st_load_param;
			st_load_param: if (cnt == 4'(PARAM_LAST)) next_state = st_load_bias;
			st_load_bias: if (cnt == 4'(`CONV_RD_LAT)) next_state = st_load_weight;
			st_load_weight: if (cnt == 4'(`CONV_RD_LAT)) next_state = st_fetch;
			st_fetch: if (cnt == 4'(FETCH_LAST)) next_state = st_multiply;
			st_multiply: next_state = st_accumulate;
			st_accumulate: next_state = ch_last ? st_write : st_load_weight;
			st_write: begin
				if (x_last && y_last && k_last)
					next_state = st_finish;
				else if (x_last && y_last)
					next_state = st_load_bias;
				else
					next_state = st_load_weight;
			end
			st_finish: if (start) next_state = st_load_param;
			default: next_state = st_idle;
		endcase
	end

	// phase counter restarts on every state change
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= st_idle;
			cnt <= '0;
		end else begin
			state <= next_state;
			cnt <= (next_state != state) ? 4'd0 : cnt + 4'd1;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			n_side <= '0;
			n_ch <= '0;
			n_ker <= '0;
			bias_q <= '0;
		end else if (state == st_load_param) begin
			if (cnt == 4'(`CONV_RD_LAT))
				n_side <= param_rdata[NW-1:0];
			if (cnt == 4'(`CONV_RD_LAT + 1))
				n_ch <= param_rdata[CW-1:0];
			if (cnt == 4'(`CONV_RD_LAT + 2))
				n_ker <= param_rdata[CW-1:0];
		end else if (state == st_load_bias && cnt == 4'(`CONV_RD_LAT)) begin
			bias_q <= bias_rdata;
		end
	end

	// kernel, row, column, channel innermost
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			x_cnt <= '0;
			y_cnt <= '0;
			ch_cnt <= '0;
			k_cnt <= '0;
		end else if (accept) begin
			x_cnt <= '0;
			y_cnt <= '0;
			ch_cnt <= '0;
			k_cnt <= '0;
		end else if (state == st_accumulate && !ch_last) begin
			ch_cnt <= ch_cnt + 1'b1;
		end else if (state == st_write) begin
			ch_cnt <= '0;
			if (!x_last) begin
				x_cnt <= x_cnt + 1'b1;
			end else begin
				x_cnt <= '0;
				if (!y_last) begin
					y_cnt <= y_cnt + 1'b1;
				end else begin
					y_cnt <= '0;
					k_cnt <= k_last ? '0 : k_cnt + 1'b1;
				end
			end
		end
	end

	// tap position in the window
	always_comb begin
		if (cnt < 4'd3) begin
			tap_row = 2'd0;
			tap_col = cnt[1:0];
		end else if (cnt < 4'd6) begin
			tap_row = 2'd1;
			tap_col = 2'(cnt - 4'd3);
		end else begin
			tap_row = 2'd2;
			tap_col = 2'(cnt - 4'd6);
		end
	end

	// -1 wraps to set the top bit
	assign yy = (XW+2)'(y_cnt) + (XW+2)'(tap_row) - (XW+2)'(1);
	assign xx = (XW+2)'(x_cnt) + (XW+2)'(tap_col) - (XW+2)'(1);
	assign pad = yy[XW+1] || xx[XW+1] || (yy >= (XW+2)'(n_side)) || (xx >= (XW+2)'(n_side));

	assign pix_lin = ch_cnt * n_sq + yy * n_side + xx;
	assign out_lin = k_cnt * n_sq + y_cnt * n_side + x_cnt;
	assign wgt_lin = k_cnt * n_ch + ch_cnt;

	assign param_req = '{cs: (state == st_load_param) && (cnt < 4'd3), we: 1'b0,
		addr: addr_t'(cnt), wdata: '0};
	assign bias_req = '{cs: (state == st_load_bias) && (cnt == 4'd0), we: 1'b0,
		addr: addr_t'(k_cnt), wdata: '0};
	assign weight_req = '{cs: (state == st_load_weight) && (cnt == 4'd0), we: 1'b0,
		addr: wgt_lin[`CONV_ADDR_W-1:0], wdata: '0};
	assign pix_req = '{cs: (state == st_fetch) && (cnt < 4'(`CONV_TAPS)) && !pad, we: 1'b0,
		addr: pix_lin[`CONV_ADDR_W-1:0], wdata: '0};

	assign wgt_load = (state == st_load_weight) && (cnt == 4'(`CONV_RD_LAT));

	assign lane_ctl = '{
		acc_init: (state == st_load_weight) && (cnt == 4'd0) && (ch_cnt == '0),
		win_clear: (state == st_fetch) && (cnt == 4'd0),
		pix_load: (state == st_fetch) && (cnt >= 4'(`CONV_RD_LAT)),
		tap_idx: cnt - 4'(`CONV_RD_LAT),
		pad: pad_q,
		mult_en: state == st_multiply,
		acc_en: state == st_accumulate,
		out_en: state == st_write,
		bias: bias_q
	};

	// write request lines up with the lane's registered byte
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			pad_q <= 1'b0;
			out_req <= '0;
			finish <= 1'b0;
		end else begin
			pad_q <= pad;
			out_req <= '{cs: state == st_write, we: state == st_write,
				addr: out_lin[`CONV_ADDR_W-1:0], wdata: '0};
			finish <= (state == st_finish) && !start;
		end
	end

	a_finish_quiet: assert property (@(posedge clk) disable iff (!rstn)
		finish |-> !(param_req.cs || bias_req.cs || weight_req.cs || pix_req.cs || out_req.cs));

	a_tap_range: assert property (@(posedge clk) disable iff (!rstn)
		lane_ctl.pix_load |-> lane_ctl.tap_idx < 4'(`CONV_TAPS));

endmodule

// ==== rtl/conv_lane.sv ====
`include "conv_cfg.svh"

module conv_lane (
	input logic clk,
	input logic rstn,
	input conv_pkg::lane_ctl_t lane_ctl,
	input conv_pkg::taps_t taps,
	input conv_pkg::word_t pix_rdata,
	output conv_pkg::pix_t result
);
	import conv_pkg::*;

	pix_t win [`CONV_TAPS];
	acc_t prod [`CONV_TAPS];
	acc_t prod_sum;
	acc_t acc;
	pix_t quant;

	// padded taps store zero
	always_ff @(posedge clk) begin
		if (lane_ctl.win_clear) begin
			for (int i = 0; i < `CONV_TAPS; i++) begin
				win[i] <= '0;
			end
		end else if (lane_ctl.pix_load) begin
			win[lane_ctl.tap_idx] <= lane_ctl.pad ? pix_t'(0) : pix_t'(pix_rdata[7:0]);
		end
	end

	always_ff @(posedge clk) begin
		if (lane_ctl.mult_en) begin
			for (int i = 0; i < `CONV_TAPS; i++) begin
				prod[i] <= win[i] * $signed(taps[i]);
			end
		end
	end

	always_comb begin
		prod_sum = '0;
		for (int i = 0; i < `CONV_TAPS; i++) begin
			prod_sum = prod_sum + prod[i];
		end
	end

	// wraps at 16 bits
	always_ff @(posedge clk) begin
		if (lane_ctl.acc_init)
			acc <= acc_t'(lane_ctl.bias[`CONV_ACC_W-1:0]);
		else if (lane_ctl.acc_en)
			acc <= acc + prod_sum;
	end

	// negative to 0, large to 0x7f, else bits 12:5
	always_comb begin
		if (acc[15])
			quant = 8'sd0;
		else if (|acc[14:12])
			quant = 8'sh7f;
		else
			quant = pix_t'(acc[12:5]);
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			result <= '0;
		else if (lane_ctl.out_en)
			result <= quant;
	end

	// window must be complete before the multiply
	a_load_vs_mult: assert property (@(posedge clk) disable iff (!rstn)
		!(lane_ctl.pix_load && lane_ctl.mult_en));

endmodule

// ==== rtl/conv_pkg.sv ====
`include "conv_cfg.svh"

package conv_pkg;

	typedef logic [`CONV_ADDR_W-1:0] addr_t;
	typedef logic [`CONV_WORD_W-1:0] word_t;

	typedef logic signed [7:0] pix_t;
	typedef logic signed [7:0] tap_t;
	typedef logic signed [`CONV_ACC_W-1:0] acc_t;

	// decoded kernel, tap 0 is top left, row major
	typedef tap_t [`CONV_TAPS-1:0] taps_t;

	typedef struct packed {
		logic cs;
		logic we;
		addr_t addr;
		word_t wdata;
	} sram_req_t;

	typedef struct packed {
		// load accumulator with bias
		logic acc_init;
		logic win_clear;
		logic pix_load;
		logic [3:0] tap_idx;
		// tap outside the image
		logic pad;
		logic mult_en;
		logic acc_en;
		logic out_en;
		word_t bias;
	} lane_ctl_t;

endpackage

// ==== rtl/weight_codebook.sv ====
`include "conv_cfg.svh"

module weight_codebook (
	input logic clk,
	input logic rstn,
	input logic start,
	input conv_pkg::word_t codebook,
	input logic wgt_load,
	input conv_pkg::word_t weight_rdata,
	output conv_pkg::taps_t taps
);
	import conv_pkg::*;

	word_t cb;

	// held for the whole run
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			cb <= '0;
		else if (start)
			cb <= codebook;
	end

	// 2-bit code picks one byte of the codebook
	always_ff @(posedge clk) begin
		if (wgt_load) begin
			for (int i = 0; i < `CONV_TAPS; i++) begin
				taps[i] <= cb[{weight_rdata[2*i +: 2], 3'b000} +: 8];
			end
		end
	end

endmodule
